// ==== all.f ====
+incdir+.
axi_sram_pkg.sv
sram_array.sv
burst_tracker.sv
read_data_buffer.sv
sram_ctrl.sv
axi_sram_top.sv
tb_axi_sram.sv

// ==== Makefile ====
TOP = tb_axi_sram

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f all.f --Mdir obj_dir -o $(TOP)

run: compile
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

// ==== tb_ref_model.svh ====
// Byte image of address bits 15:0, shared by both regions
logic [7:0] model_mem [0:65535];
bit         model_set [0:65535];    // Byte holds a known value
int         stall_run;

function automatic logic [1:0] expected_resp(bit wr, logic [31:0] addr, axi_size_t size);
    logic [1:0] resp;
    if (size > 3'd2) begin
        resp = `RESP_SLVERR;
    end else if (wr && addr < 32'h0001_0000) begin
        resp = `RESP_SLVERR;            // Read-only alias
    end else if (addr >= 32'h0002_0000) begin
        resp = `RESP_DECERR;
    end else begin
        resp = `RESP_OKAY;
    end
    return resp;
endfunction

function automatic logic [31:0] step_addr(logic [31:0] addr, axi_size_t size,
                                          axi_burst_t burst);
    return (burst == `BURST_INCR) ? addr + (32'd1 << size) : addr;
endfunction

// Random READY with a bounded run of low cycles
function automatic bit draw_ready();
    if (stall_run < MAX_STALL && $urandom_range(3) == 0) begin
        stall_run++;
        return 1'b0;
    end
    stall_run = 0;
    return 1'b1;
endfunction

task automatic model_write(logic [31:0] addr, logic [31:0] data, logic [3:0] strb);
    logic [15:0] idx;
    for (int k = 0; k < 4; k++) begin
        idx = {addr[15:2], 2'(k)};
        if (strb[k]) begin
            model_mem[idx] = data[8*k +: 8];
            model_set[idx] = 1'b1;
        end
    end
endtask

task automatic expect_word(logic [31:0] addr, bit ok, output logic [31:0] data,
                           output logic [31:0] mask);
    logic [15:0] idx;
    data = '0;
    mask = ok ? 32'h0 : 32'hFFFF_FFFF;  // Error beats read as zero
    for (int k = 0; k < 4; k++) begin
        idx = {addr[15:2], 2'(k)};
        if (ok && model_set[idx]) begin
            data[8*k +: 8] = model_mem[idx];
            mask[8*k +: 8] = 8'hFF;
        end
    end
endtask

task automatic write_burst(string name, axi_id_t id, logic [31:0] addr, axi_len_t len,
                           axi_size_t size, axi_burst_t burst, bit race_ar);
    logic [1:0] resp;
    bit         done;
    resp = expected_resp(1'b1, addr, size);
    @(negedge ACLK);
    AWID    = id;
    AWADDR  = addr;
    AWLEN   = len;
    AWSIZE  = size;
    AWBURST = burst;
    AWVALID = 1'b1;
    ARVALID = race_ar;                  // AR fields set by the caller
    if (race_ar) begin
        #1;
        check({name, " arready"}, 32'd0, 32'(ARREADY));
    end
    do begin
        #1;
        done = AWREADY;
        @(negedge ACLK);
    end while (!done);
    AWVALID = 1'b0;
    for (int b = 0; b <= int'(len); b++) begin
        WDATA = $urandom;
        WSTRB = (size == 3'd2 && burst == `BURST_INCR) ? 4'hF : 4'($urandom);
        WLAST = (b == int'(len));
        do begin
            WVALID = draw_ready();
            #1;
            done = WVALID && WREADY;
            @(negedge ACLK);
        end while (!done);
        if (resp == `RESP_OKAY) begin
            model_write(addr, WDATA, WSTRB);
        end
        addr = step_addr(addr, size, burst);
    end
    WVALID = 1'b0;
    do begin
        BREADY = draw_ready();
        #1;
        done = BVALID && BREADY;
        if (BVALID) begin
            check({name, " bresp"}, 32'(resp), 32'(BRESP));
            check({name, " bid"}, 32'(id), 32'(BID));
        end
        @(negedge ACLK);
    end while (!done);
    BREADY = 1'b0;
endtask

task automatic read_burst(string name, axi_id_t id, logic [31:0] addr, axi_len_t len,
                          axi_size_t size, axi_burst_t burst, bit ar_pending);
    logic [1:0]  resp;
    logic [31:0] exp_data;
    logic [31:0] mask;
    bit          done;
    resp = expected_resp(1'b0, addr, size);
    if (!ar_pending) begin
        @(negedge ACLK);
        ARID    = id;
        ARADDR  = addr;
        ARLEN   = len;
        ARSIZE  = size;
        ARBURST = burst;
        ARVALID = 1'b1;
    end
    do begin
        #1;
        done = ARREADY;
        @(negedge ACLK);
    end while (!done);
    ARVALID = 1'b0;
    for (int b = 0; b <= int'(len); b++) begin
        expect_word(addr, resp == `RESP_OKAY, exp_data, mask);
        do begin
            RREADY = draw_ready();
            #1;
            done = RVALID && RREADY;
            if (RVALID) begin           // Held beat must match on every cycle
                check({name, " rdata"}, exp_data & mask, RDATA & mask);
                check({name, " rresp"}, 32'(resp), 32'(RRESP));
                check({name, " rlast"}, 32'(b == int'(len)), 32'(RLAST));
                check({name, " rid"}, 32'(id), 32'(RID));
            end
            @(negedge ACLK);
        end while (!done);
        addr = step_addr(addr, size, burst);
    end
    RREADY = 1'b0;
endtask

// ==== tb_axi_sram.sv ====
`timescale 1ns/100ps

`include "sram_params.svh"

module tb_axi_sram
    import axi_sram_pkg::*;
();

    localparam int CLK_PERIOD  = 40;
    localparam int MAX_STALL   = 3;
    localparam int TXN_LIMIT   = 64;
    localparam int BEAT_CYCLES = 8;     // Read beat of 3 cycles plus stalls

    logic       ACLK;
    logic       ARESETn;
    axi_id_t    AWID, BID, ARID, RID;
    axi_addr_t  AWADDR, ARADDR;
    axi_len_t   AWLEN, ARLEN;
    axi_size_t  AWSIZE, ARSIZE;
    axi_burst_t AWBURST, ARBURST;
    axi_data_t  WDATA, RDATA;
    axi_strb_t  WSTRB;
    axi_resp_t  BRESP, RRESP;
    logic       AWVALID, AWREADY, WLAST, WVALID, WREADY, BVALID, BREADY;
    logic       ARVALID, ARREADY, RLAST, RVALID, RREADY;

    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;

    axi_sram_top UUT (.*);

    task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic finish_test(string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    `include "tb_ref_model.svh"

    initial begin
        ACLK = 1'b0;
        forever #(CLK_PERIOD / 2) ACLK = ~ACLK;
    end

    initial begin
        #(TXN_LIMIT * 17 * BEAT_CYCLES * CLK_PERIOD);
        $display("Watchdog expired, the DUT never completed a handshake");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] last;
        axi_id_t     id;
        axi_len_t    len;
        axi_size_t   size;

        void'($urandom(1635));
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        stall_run    = 0;
        {AWID, AWADDR, AWLEN, AWSIZE, AWBURST, AWVALID} = '0;
        {WDATA, WSTRB, WLAST, WVALID, BREADY} = '0;
        {ARID, ARADDR, ARLEN, ARSIZE, ARBURST, ARVALID, RREADY} = '0;
        ARESETn = 1'b0;
        repeat (2) @(posedge ACLK);
        @(negedge ACLK);
        ARESETn = 1'b1;
        #1;
        check("reset_state awready", 32'd1, 32'(AWREADY));
        check("reset_state arready", 32'd1, 32'(ARREADY));
        check("reset_state wready", 32'd0, 32'(WREADY));
        check("reset_state bvalid", 32'd0, 32'(BVALID));
        check("reset_state rvalid", 32'd0, 32'(RVALID));
        finish_test("reset_state");

        repeat (8) begin
            addr = 32'h0001_0000 + ($urandom_range(63) << 2);
            len  = 4'($urandom);
            id   = 4'($urandom);
            write_burst("incr_word", id, addr, len, 3'd2, `BURST_INCR, 1'b0);
            read_burst("incr_word", id + 4'd1, addr, len, 3'd2, `BURST_INCR, 1'b0);
        end
        finish_test("incr_word");

        repeat (6) begin
            addr = 32'h0001_0000 + $urandom_range(255);
            len  = 4'($urandom);
            size = 3'($urandom_range(1));
            write_burst("incr_strobe", 4'($urandom), addr, len, size, `BURST_INCR, 1'b0);
            last = addr + (32'(len) << size);
            read_burst("incr_strobe", 4'($urandom), {addr[31:2], 2'b00},
                       4'(last[31:2] - addr[31:2]), 3'd2, `BURST_INCR, 1'b0);
        end
        finish_test("incr_strobe");

        repeat (4) begin
            addr = 32'h0001_0000 + ($urandom_range(63) << 2);
            len  = 4'($urandom);
            write_burst("fixed_burst", 4'($urandom), addr, len, 3'd2, `BURST_FIXED, 1'b0);
            read_burst("fixed_burst", 4'($urandom), addr, len, 3'd2, `BURST_FIXED, 1'b0);
        end
        finish_test("fixed_burst");

        addr = 32'h0001_0000 + ($urandom_range(63) << 2);
        write_burst("ro_alias", 4'd1, addr, 4'd0, 3'd2, `BURST_INCR, 1'b0);
        write_burst("ro_alias", 4'd2, addr - 32'h0001_0000, 4'd3, 3'd2, `BURST_INCR, 1'b0);
        read_burst("ro_alias", 4'd3, addr, 4'd3, 3'd2, `BURST_INCR, 1'b0);
        read_burst("ro_alias", 4'd4, addr - 32'h0001_0000, 4'd3, 3'd2, `BURST_INCR, 1'b0);
        finish_test("ro_alias");

        write_burst("decode_err", 4'd5, 32'h0002_0000 + $urandom_range(4095),
                    4'($urandom), 3'd2, `BURST_INCR, 1'b0);
        read_burst("decode_err", 4'd6, 32'h0003_0000 + $urandom_range(4095),
                   4'($urandom), 3'd1, `BURST_INCR, 1'b0);
        finish_test("decode_err");

        write_burst("size_err", 4'd7, 32'h0001_0100, 4'd2, 3'd3, `BURST_INCR, 1'b0);
        read_burst("size_err", 4'd8, 32'h0001_0100, 4'd5, 3'd3, `BURST_INCR, 1'b0);
        finish_test("size_err");

        repeat (3) begin
            addr    = 32'h0001_0000 + ($urandom_range(63) << 2);
            len     = 4'($urandom);
            id      = 4'($urandom);
            ARID    = id + 4'd8;
            ARADDR  = addr;
            ARLEN   = len;
            ARSIZE  = 3'd2;
            ARBURST = `BURST_INCR;
            write_burst("write_first", id, addr, len, 3'd2, `BURST_INCR, 1'b1);
            read_burst("write_first", id + 4'd8, addr, len, 3'd2, `BURST_INCR, 1'b1);
        end
        finish_test("write_first");

        $display("%0d tests, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== axi_sram_top.sv ====
`timescale 1ns/100ps

module axi_sram_top
    import axi_sram_pkg::*;
(
    input  logic       ACLK,
    input  logic       ARESETn,

    input  axi_id_t    AWID,
    input  axi_addr_t  AWADDR,
    input  axi_len_t   AWLEN,
    input  axi_size_t  AWSIZE,
    input  axi_burst_t AWBURST,
    input  logic       AWVALID,
    output logic       AWREADY,

    input  axi_data_t  WDATA,
    input  axi_strb_t  WSTRB,
    input  logic       WLAST,      // Beat count comes from AWLEN
    input  logic       WVALID,
    output logic       WREADY,

    output axi_id_t    BID,
    output axi_resp_t  BRESP,
    output logic       BVALID,
    input  logic       BREADY,

    input  axi_id_t    ARID,
    input  axi_addr_t  ARADDR,
    input  axi_len_t   ARLEN,
    input  axi_size_t  ARSIZE,
    input  axi_burst_t ARBURST,
    input  logic       ARVALID,
    output logic       ARREADY,

    output axi_id_t    RID,
    output axi_data_t  RDATA,
    output axi_resp_t  RRESP,
    output logic       RLAST,
    output logic       RVALID,
    input  logic       RREADY
);

    logic       load;
    logic       is_write;
    logic       advance;
    logic       mem_read;
    axi_strb_t  mem_write;
    logic       capture;
    axi_resp_t  resp;
    logic       last_beat;
    axi_id_t    txn_id;
    sram_addr_t sram_addr;
    axi_data_t  rdata;

    sram_ctrl u_ctrl (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .AWVALID   (AWVALID),
        .ARVALID   (ARVALID),
        .WVALID    (WVALID),
        .WSTRB     (WSTRB),
        .BREADY    (BREADY),
        .RVALID    (RVALID),
        .RREADY    (RREADY),
        .resp      (resp),
        .last_beat (last_beat),
        .txn_id    (txn_id),
        .AWREADY   (AWREADY),
        .ARREADY   (ARREADY),
        .WREADY    (WREADY),
        .BVALID    (BVALID),
        .BID       (BID),
        .BRESP     (BRESP),
        .load      (load),
        .is_write  (is_write),
        .advance   (advance),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .capture   (capture)
    );

    burst_tracker u_tracker (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .load      (load),
        .is_write  (is_write),
        .advance   (advance),
        .AWID      (AWID),
        .AWADDR    (AWADDR),
        .AWLEN     (AWLEN),
        .AWSIZE    (AWSIZE),
        .AWBURST   (AWBURST),
        .ARID      (ARID),
        .ARADDR    (ARADDR),
        .ARLEN     (ARLEN),
        .ARSIZE    (ARSIZE),
        .ARBURST   (ARBURST),
        .sram_addr (sram_addr),
        .last_beat (last_beat),
        .resp      (resp),
        .txn_id    (txn_id)
    );

    sram_array u_array (
        .ACLK      (ACLK),
        .sram_addr (sram_addr),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .WDATA     (WDATA),
        .rdata     (rdata)
    );

    read_data_buffer u_rbuf (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .capture   (capture),
        .rdata     (rdata),
        .resp      (resp),
        .last_beat (last_beat),
        .txn_id    (txn_id),
        .RREADY    (RREADY),
        .RVALID    (RVALID),
        .RDATA     (RDATA),
        .RRESP     (RRESP),
        .RLAST     (RLAST),
        .RID       (RID)
    );

endmodule

// ==== sram_ctrl.sv ====
`timescale 1ns/100ps

`include "sram_params.svh"

module sram_ctrl
    import axi_sram_pkg::*;
(
    input  logic      ACLK,
    input  logic      ARESETn,

    input  logic      AWVALID,
    input  logic      ARVALID,
    input  logic      WVALID,
    input  axi_strb_t WSTRB,
    input  logic      BREADY,
    input  logic      RVALID,
    input  logic      RREADY,

    input  axi_resp_t resp,
    input  logic      last_beat,
    input  axi_id_t   txn_id,

    output logic      AWREADY,
    output logic      ARREADY,
    output logic      WREADY,
    output logic      BVALID,
    output axi_id_t   BID,
    output axi_resp_t BRESP,

    output logic      load,
    output logic      is_write,
    output logic      advance,
    output logic      mem_read,
    output axi_strb_t mem_write,
    output logic      capture
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;

    logic aw_hs;
    logic ar_hs;
    logic w_hs;
    logic b_hs;
    logic r_hs;
    logic resp_ok;

    // Handshake ready signals follow the state directly
    assign AWREADY = (state == IDLE);
    assign ARREADY = (state == IDLE) && !AWVALID;   // Write wins a tie
    assign WREADY  = (state == W_DATA);
    assign BVALID  = (state == B_RESP);

    assign aw_hs = AWVALID && AWREADY;
    assign ar_hs = ARVALID && ARREADY;
    assign w_hs  = WVALID && WREADY;
    assign b_hs  = BVALID && BREADY;
    assign r_hs  = RVALID && RREADY && (state == R_WAIT);

    assign resp_ok = (resp == `RESP_OKAY);

    assign load     = aw_hs || ar_hs;
    assign is_write = aw_hs;
    assign advance  = w_hs || r_hs;

    // Errored transactions never touch the array
    assign mem_write = (w_hs && resp_ok) ? WSTRB : '0;
    assign mem_read  = (state == R_ISSUE) && resp_ok;

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (aw_hs) begin
                    state_nxt = W_DATA;
                end else if (ar_hs) begin
                    state_nxt = R_ISSUE;
                end
            end
            W_DATA: begin
                if (w_hs && last_beat) begin
                    state_nxt = B_RESP;
                end
            end
            B_RESP: begin
                if (b_hs) begin
                    state_nxt = IDLE;
                end
            end
            R_ISSUE: begin
                state_nxt = R_WAIT;                  // Array data lands next cycle
            end
            R_WAIT: begin
                if (r_hs) begin
                    state_nxt = last_beat ? IDLE : R_ISSUE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // Buffer load strobe, one cycle behind the array read
    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            capture <= 1'b0;
        end else begin
            capture <= (state == R_ISSUE);
        end
    end

    // B payload frozen at the last W beat
    always_ff @(posedge ACLK) begin
        if (w_hs && last_beat) begin
            BID   <= txn_id;
            BRESP <= resp;
        end
    end

endmodule

// ==== read_data_buffer.sv ====
`timescale 1ns/100ps

module read_data_buffer
    import axi_sram_pkg::*;
(
    input  logic      ACLK,
    input  logic      ARESETn,
    input  logic      capture,
    input  axi_data_t rdata,
    input  axi_resp_t resp,
    input  logic      last_beat,
    input  axi_id_t   txn_id,
    input  logic      RREADY,

    output logic      RVALID,
    output axi_data_t RDATA,
    output axi_resp_t RRESP,
    output logic      RLAST,
    output axi_id_t   RID
);

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            RVALID <= 1'b0;
        end else if (capture) begin
            RVALID <= 1'b1;
        end else if (RVALID && RREADY) begin
            RVALID <= 1'b0;                          // Beat accepted
        end
    end

    // Held until the next capture, stable under back-pressure
    always_ff @(posedge ACLK) begin
        if (capture) begin
            RDATA <= rdata;
            RRESP <= resp;
            RLAST <= last_beat;
            RID   <= txn_id;
        end
    end

endmodule

// ==== burst_tracker.sv ====
`timescale 1ns/100ps

`include "sram_params.svh"

module burst_tracker
    import axi_sram_pkg::*;
(
    input  logic       ACLK,
    input  logic       ARESETn,
    input  logic       load,
    input  logic       is_write,
    input  logic       advance,

    input  axi_id_t    AWID,
    input  axi_addr_t  AWADDR,
    input  axi_len_t   AWLEN,
    input  axi_size_t  AWSIZE,
    input  axi_burst_t AWBURST,
    input  axi_id_t    ARID,
    input  axi_addr_t  ARADDR,
    input  axi_len_t   ARLEN,
    input  axi_size_t  ARSIZE,
    input  axi_burst_t ARBURST,

    output sram_addr_t sram_addr,
    output logic       last_beat,
    output axi_resp_t  resp,
    output axi_id_t    txn_id
);

    axi_addr_t  sel_addr;
    axi_size_t  sel_size;
    axi_resp_t  sel_resp;
    axi_addr_t  addr;
    axi_len_t   len;
    axi_len_t   beat;
    axi_size_t  size;
    axi_burst_t burst;

    assign sel_addr = is_write ? AWADDR : ARADDR;
    assign sel_size = is_write ? AWSIZE : ARSIZE;

    always_comb begin
        if (sel_size > `AXI_MAX_SIZE) begin
            sel_resp = `RESP_SLVERR;
        end else if (is_write && sel_addr <= `SRAM_RO_LIMIT) begin
            sel_resp = `RESP_SLVERR;                 // Read-only alias
        end else if (sel_addr > `SRAM_RW_LIMIT) begin
            sel_resp = `RESP_DECERR;
        end else begin
            sel_resp = `RESP_OKAY;
        end
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            len   <= '0;
            beat  <= '0;
            size  <= '0;
            burst <= `BURST_FIXED;
            resp  <= `RESP_OKAY;
        end else if (load) begin
            len   <= is_write ? AWLEN : ARLEN;
            beat  <= '0;
            size  <= sel_size;
            burst <= is_write ? AWBURST : ARBURST;
            resp  <= sel_resp;
        end else if (advance) begin
            beat  <= beat + 1'b1;
        end
    end

    always_ff @(posedge ACLK) begin
        if (load) begin
            addr   <= sel_addr;
            txn_id <= is_write ? AWID : ARID;
        end else if (advance && burst == `BURST_INCR) begin
            addr   <= addr + (axi_addr_t'(1) << size);
        end
    end

    // Both regions map onto the same words
    assign sram_addr = addr[`SRAM_ADDR_BITS+1:2];
    assign last_beat = (beat == len);

endmodule

// ==== sram_array.sv ====
`timescale 1ns/100ps

`include "sram_params.svh"

module sram_array
    import axi_sram_pkg::*;
(
    input  logic       ACLK,
    input  sram_addr_t sram_addr,
    input  logic       mem_read,
    input  axi_strb_t  mem_write,
    input  axi_data_t  WDATA,
    output axi_data_t  rdata
);

    axi_data_t mem [0:(1 << `SRAM_ADDR_BITS)-1];

    // Byte lanes write independently
    always_ff @(posedge ACLK) begin
        for (int i = 0; i < `AXI_STRB_BITS; i++) begin
            if (mem_write[i]) begin
                mem[sram_addr][8*i +: 8] <= WDATA[8*i +: 8];
            end
        end
    end

    // Zero when idle so error beats read as zero
    always_ff @(posedge ACLK) begin
        if (mem_read) begin
            rdata <= mem[sram_addr];
        end else begin
            rdata <= '0;
        end
    end

endmodule

// ==== axi_sram_pkg.sv ====
`include "sram_params.svh"

package axi_sram_pkg;

    typedef logic [`AXI_ID_BITS-1:0]    axi_id_t;
    typedef logic [`AXI_ADDR_BITS-1:0]  axi_addr_t;    // Byte address
    typedef logic [`AXI_DATA_BITS-1:0]  axi_data_t;
    typedef logic [`AXI_STRB_BITS-1:0]  axi_strb_t;    // One bit per byte lane
    typedef logic [`AXI_LEN_BITS-1:0]   axi_len_t;     // Beats minus one
    typedef logic [`AXI_SIZE_BITS-1:0]  axi_size_t;    // Log2 of bytes per beat
    typedef logic [1:0]                 axi_burst_t;
    typedef logic [1:0]                 axi_resp_t;
    typedef logic [`SRAM_ADDR_BITS-1:0] sram_addr_t;   // Word index

    // One transaction at a time, write first
    typedef enum logic [2:0] {
        IDLE,
        W_DATA,
        B_RESP,
        R_ISSUE,
        R_WAIT
    } ctrl_state_t;

endpackage

// ==== sram_params.svh ====
`ifndef SRAM_PARAMS_SVH
`define SRAM_PARAMS_SVH

`define AXI_ID_BITS     4
`define AXI_ADDR_BITS   32
`define AXI_DATA_BITS   32
`define AXI_STRB_BITS   4
`define AXI_LEN_BITS    4
`define AXI_SIZE_BITS   3

`define SRAM_ADDR_BITS  14              // 16K words
`define SRAM_RO_LIMIT   32'h0000_FFFF   // Top of the read-only alias
`define SRAM_RW_LIMIT   32'h0001_FFFF   // Top of the writable region

`define AXI_MAX_SIZE    3'd2            // 4 bytes per beat
`define BURST_FIXED     2'b00
`define BURST_INCR      2'b01
`define RESP_OKAY       2'b00
`define RESP_SLVERR     2'b10
`define RESP_DECERR     2'b11

`endif
